// File: source/comb_settings.svh
`ifndef COMB_SETTINGS_SVH
`define COMB_SETTINGS_SVH

// Audio sample format
`define SAMPLE_WIDTH 12

// Delay line depth in samples, kept short for simulation
`define DELAY_MAX 64
// Delay length word
`define DELAY_WIDTH 16

// Feedback gain, signed Q1.7
`define GAIN_WIDTH 8
`define GAIN_FRAC 7

// Filter count, power of two only
`define NUM_COMBS 4
`define COMB_IDX_WIDTH 2

`endif

// File: source/audio_sample_pkg.sv
`include "comb_settings.svh"

package audio_sample_pkg;

    ////////////////////
    // Sample types
    ////////////////////

    // One audio sample, two's complement
    typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

    // Sum of all filter outputs
    // One extra bit per doubling of the filter count
    typedef logic signed [`SAMPLE_WIDTH+`COMB_IDX_WIDTH-1:0] acc_t;

endpackage

// File: source/comb_config_pkg.sv
`include "comb_settings.svh"

package comb_config_pkg;

    ////////////////////
    // Config types
    ////////////////////

    // Delay length in samples
    // Valid range 1 to DELAY_MAX once written
    typedef logic [`DELAY_WIDTH-1:0] delay_len_t;

    // Feedback gain, signed fixed point
    typedef logic signed [`GAIN_WIDTH-1:0] gain_t;

    // Selects one filter of the bank
    typedef logic [`COMB_IDX_WIDTH-1:0] comb_idx_t;

endpackage

// File: source/sample_delay_line.sv
`timescale 1ns/10ps

`include "comb_settings.svh"

module sample_delay_line
    import audio_sample_pkg::*, comb_config_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       enable,
    input  delay_len_t len,
    input  sample_t    in_sample,
    output sample_t    out_sample
);

    // Index bits for the shift register
    localparam int IDX_WIDTH = $clog2(`DELAY_MAX);

    // Entry 0 holds the newest sample
    sample_t queue [`DELAY_MAX];

    // Tap position
    logic [IDX_WIDTH-1:0] tap_idx;

    ////////////////////
    // Shift register
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < `DELAY_MAX; i++) begin
                queue[i] <= '0;
            end
        end else if (enable) begin
            // One shift per audio sample
            queue[0] <= in_sample;
            for (int i = 1; i < `DELAY_MAX; i++) begin
                queue[i] <= queue[i-1];
            end
        end
    end

    ////////////////////
    // Output tap
    ////////////////////

    // Length counts from 1, so entry len-1 was written len shifts ago
    assign tap_idx = IDX_WIDTH'(len - delay_len_t'(1));

    assign out_sample = queue[tap_idx];

endmodule

// File: source/comb_filter.sv
`timescale 1ns/10ps

`include "comb_settings.svh"

module comb_filter
    import audio_sample_pkg::*, comb_config_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       sample_valid,
    input  sample_t    sample_in,
    input  delay_len_t delay_len,
    input  gain_t      gain,
    output sample_t    comb_out
);

    // Full product and one guard bit for the add
    localparam int PROD_WIDTH = `SAMPLE_WIDTH + `GAIN_WIDTH;
    localparam int SUM_WIDTH  = PROD_WIDTH + 1;

    // Sample range limits
    localparam sample_t SAT_HI = {1'b0, {(`SAMPLE_WIDTH-1){1'b1}}};
    localparam sample_t SAT_LO = {1'b1, {(`SAMPLE_WIDTH-1){1'b0}}};

    // Own output from delay_len samples ago
    sample_t tap;

    logic signed [PROD_WIDTH-1:0] product;
    logic signed [PROD_WIDTH-1:0] scaled;
    logic signed [SUM_WIDTH-1:0]  sum;

    ////////////////////
    // Feedback store
    ////////////////////

    // Output goes back in on each sample strobe
    sample_delay_line u_delay (
        .clk        (clk),
        .rstn       (rstn),
        .enable     (sample_valid),
        .len        (delay_len),
        .in_sample  (comb_out),
        .out_sample (tap)
    );

    ////////////////////
    // Scale and add
    ////////////////////

    // Signed multiply at full width
    assign product = PROD_WIDTH'(tap) * PROD_WIDTH'(gain);

    // Drop the gain fraction bits
    assign scaled = product >>> `GAIN_FRAC;

    assign sum = SUM_WIDTH'(sample_in) + SUM_WIDTH'(scaled);

    // Clamp to the sample range
    always_comb begin
        if (sum > SUM_WIDTH'(SAT_HI)) begin
            comb_out = SAT_HI;
        end else if (sum < SUM_WIDTH'(SAT_LO)) begin
            comb_out = SAT_LO;
        end else begin
            comb_out = sample_t'(sum);
        end
    end

endmodule

// File: source/comb_config_regs.sv
`timescale 1ns/10ps

`include "comb_settings.svh"

module comb_config_regs
    import comb_config_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       cfg_write,
    input  comb_idx_t  cfg_index,
    input  delay_len_t cfg_delay,
    input  gain_t      cfg_gain,
    output delay_len_t delay_len [`NUM_COMBS],
    output gain_t      gain      [`NUM_COMBS]
);

    // Longest legal delay in the length format
    localparam delay_len_t LEN_MAX = delay_len_t'(`DELAY_MAX);

    // Written delay after range limiting
    delay_len_t delay_clamped;

    ////////////////////
    // Range check
    ////////////////////

    always_comb begin
        if (cfg_delay == '0) begin
            // Zero delay has no tap
            delay_clamped = delay_len_t'(1);
        end else if (cfg_delay > LEN_MAX) begin
            delay_clamped = LEN_MAX;
        end else begin
            delay_clamped = cfg_delay;
        end
    end

    ////////////////////
    // Per filter registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            // Longest delay and no feedback
            for (int k = 0; k < `NUM_COMBS; k++) begin
                delay_len[k] <= LEN_MAX;
                gain[k]      <= '0;
            end
        end else if (cfg_write) begin
            // Only the indexed filter changes
            delay_len[cfg_index] <= delay_clamped;
            gain[cfg_index]      <= cfg_gain;
        end
    end

endmodule

// File: source/comb_mixer.sv
`timescale 1ns/10ps

`include "comb_settings.svh"

module comb_mixer
    import audio_sample_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  logic    sample_valid,
    input  sample_t comb_out [`NUM_COMBS],
    output sample_t sample_out,
    output logic    out_valid
);

    // Running sum over the bank
    acc_t sum;

    // Sum divided by the filter count
    acc_t avg;

    ////////////////////
    // Sum
    ////////////////////

    always_comb begin
        sum = '0;
        for (int k = 0; k < `NUM_COMBS; k++) begin
            // Sign extend each filter output first
            sum = sum + acc_t'(comb_out[k]);
        end
    end

    // Average by shift, count is a power of two
    assign avg = sum >>> `COMB_IDX_WIDTH;

    ////////////////////
    // Output register
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            sample_out <= '0;
        end else if (sample_valid) begin
            // Average fits the sample range again
            sample_out <= sample_t'(avg);
        end
    end

    // Strobe lines up with the new sample
    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= sample_valid;
        end
    end

endmodule

// File: source/comb_bank_top.sv
`timescale 1ns/10ps

`include "comb_settings.svh"

module comb_bank_top
    import audio_sample_pkg::*, comb_config_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    // Audio in
    input  logic       sample_valid,
    input  sample_t    sample_in,
    // Config write
    input  logic       cfg_write,
    input  comb_idx_t  cfg_index,
    input  delay_len_t cfg_delay,
    input  gain_t      cfg_gain,
    // Mixed audio out
    output sample_t    sample_out,
    output logic       out_valid
);

    // Config levels, one pair per filter
    delay_len_t delay_len [`NUM_COMBS];
    gain_t      gain      [`NUM_COMBS];

    // Filter outputs into the mixer
    sample_t    comb_out  [`NUM_COMBS];

    ////////////////////
    // Configuration
    ////////////////////

    comb_config_regs u_cfg (
        .clk       (clk),
        .rstn      (rstn),
        .cfg_write (cfg_write),
        .cfg_index (cfg_index),
        .cfg_delay (cfg_delay),
        .cfg_gain  (cfg_gain),
        .delay_len (delay_len),
        .gain      (gain)
    );

    ////////////////////
    // Filter bank
    ////////////////////

    // Same input sample to every filter
    for (genvar k = 0; k < `NUM_COMBS; k++) begin : g_comb
        comb_filter u_comb (
            .clk          (clk),
            .rstn         (rstn),
            .sample_valid (sample_valid),
            .sample_in    (sample_in),
            .delay_len    (delay_len[k]),
            .gain         (gain[k]),
            .comb_out     (comb_out[k])
        );
    end

    ////////////////////
    // Mixer
    ////////////////////

    comb_mixer u_mix (
        .clk          (clk),
        .rstn         (rstn),
        .sample_valid (sample_valid),
        .comb_out     (comb_out),
        .sample_out   (sample_out),
        .out_valid    (out_valid)
    );

endmodule

// File: tests/comb_bank_sva.sv
`timescale 1ns/10ps

`include "comb_settings.svh"

module comb_bank_sva
    import audio_sample_pkg::*;
(
    input logic    clk,
    input logic    rstn,
    input logic    sample_valid,
    input logic    out_valid,
    input sample_t sample_out
);

    ////////////////////
    // Output strobe timing
    ////////////////////

    // Each sample strobe gives an output strobe one clock later
    a_out_follows: assert property (
        @(posedge clk) disable iff (!rstn) sample_valid |=> out_valid
    ) else $error("out_valid did not follow sample_valid after one clock");

    // No output strobe without a sample strobe the clock before
    a_out_has_cause: assert property (
        @(posedge clk) disable iff (!rstn) out_valid |-> $past(sample_valid)
    ) else $error("out_valid seen without sample_valid on the previous clock");

    ////////////////////
    // Reset
    ////////////////////

    a_reset_quiet: assert property (
        @(posedge clk) !rstn |=> (!out_valid && sample_out == '0)
    ) else $error("out_valid or sample_out not zero during reset");

endmodule

// Checker on the top level of the bank
bind comb_bank_top comb_bank_sva u_sva (
    .clk          (clk),
    .rstn         (rstn),
    .sample_valid (sample_valid),
    .out_valid    (out_valid),
    .sample_out   (sample_out)
);

// File: tests/comb_bank_tb.sv
`timescale 1ns/10ps

`include "comb_settings.svh"

module comb_bank_tb
    import audio_sample_pkg::*, comb_config_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int NUM_ROWS   = 6;
    localparam int SAT_MAX    = (1 << (`SAMPLE_WIDTH - 1)) - 1;
    localparam int SAT_MIN    = -(1 << (`SAMPLE_WIDTH - 1));

    logic       clk;
    logic       rstn;
    logic       sample_valid;
    sample_t    sample_in;
    logic       cfg_write;
    comb_idx_t  cfg_index;
    delay_len_t cfg_delay;
    gain_t      cfg_gain;
    sample_t    sample_out;
    logic       out_valid;

    // Stimulus table with one entry per test
    string row_name    [NUM_ROWS];
    int    row_delay   [NUM_ROWS][`NUM_COMBS];
    int    row_gain    [NUM_ROWS][`NUM_COMBS];
    int    row_amp     [NUM_ROWS];  // impulse height or random bound
    bit    row_random  [NUM_ROWS];
    bit    row_sat     [NUM_ROWS];  // full scale random with clamping expected
    int    row_count   [NUM_ROWS];
    int    row_gap     [NUM_ROWS];  // idle clocks after each sample
    int    row_switch  [NUM_ROWS];  // sample index of a filter 0 delay rewrite
    int    row_new_len [NUM_ROWS];

    // Reference model state with the newest entry at index 0
    int hist       [`NUM_COMBS][`DELAY_MAX];
    int model_len  [`NUM_COMBS];
    int model_gain [`NUM_COMBS];
    int clamp_hits;
    int errors;
    int checks;
    bit table_ready;

    comb_bank_top uut (
        .clk          (clk),
        .rstn         (rstn),
        .sample_valid (sample_valid),
        .sample_in    (sample_in),
        .cfg_write    (cfg_write),
        .cfg_index    (cfg_index),
        .cfg_delay    (cfg_delay),
        .cfg_gain     (cfg_gain),
        .sample_out   (sample_out),
        .out_valid    (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////
    // Reference model
    ////////////////////

    function automatic int clamp_sample(input int value);
        if (value > SAT_MAX) return SAT_MAX;
        if (value < SAT_MIN) return SAT_MIN;
        return value;
    endfunction

    // Written delays are limited to 1 .. DELAY_MAX
    function automatic int clamp_len(input int len);
        if (len < 1) return 1;
        if (len > `DELAY_MAX) return `DELAY_MAX;
        return len;
    endfunction

    task automatic model_reset();
        for (int k = 0; k < `NUM_COMBS; k++) begin
            model_len[k]  = `DELAY_MAX;
            model_gain[k] = 0;
            for (int i = 0; i < `DELAY_MAX; i++) begin
                hist[k][i] = 0;
            end
        end
    endtask

    task automatic model_step(input int in_value, output int expected);
        int total;
        int tap;
        int raw;
        int outs [`NUM_COMBS];
        total = 0;
        for (int k = 0; k < `NUM_COMBS; k++) begin
            tap = hist[k][model_len[k] - 1];
            // Q1.7 gain with the fraction dropped by arithmetic shift
            raw = in_value + ((tap * model_gain[k]) >>> `GAIN_FRAC);
            outs[k] = clamp_sample(raw);
            if (outs[k] != raw) clamp_hits++;
            total += outs[k];
        end
        // Feedback into each history
        for (int k = 0; k < `NUM_COMBS; k++) begin
            for (int i = `DELAY_MAX - 1; i > 0; i--) begin
                hist[k][i] = hist[k][i - 1];
            end
            hist[k][0] = outs[k];
        end
        expected = total >>> $clog2(`NUM_COMBS);
    endtask

    ////////////////////
    // Driving and checking
    ////////////////////

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic reset_bank(input string name);
        rstn = 1'b0;
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        model_reset();
        // Quiet outputs until the first sample strobe
        repeat (2) begin
            @(negedge clk);
            check_value({name, " reset out_valid"}, 0, int'(out_valid));
            check_value({name, " reset sample_out"}, 0, int'(sample_out));
        end
    endtask

    task automatic write_config(input int index, input int len, input int gain_value);
        cfg_write = 1'b1;
        cfg_index = comb_idx_t'(index);
        cfg_delay = delay_len_t'(len);
        cfg_gain  = gain_t'(gain_value);
        @(negedge clk);
        cfg_write = 1'b0;
        model_len[index]  = clamp_len(len);
        model_gain[index] = gain_value;
    endtask

    task automatic apply_sample(input string name, input int value);
        int expected;
        int waited;
        model_step(value, expected);
        sample_valid = 1'b1;
        sample_in    = sample_t'(value);
        @(negedge clk);
        sample_valid = 1'b0;
        waited = 0;
        while (!out_valid && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (!out_valid) begin
            errors++;
            $display("%s: no output strobe followed the sample strobe", name);
        end else begin
            // Strobe is due one clock after the sample
            check_value({name, " strobe delay"}, 0, waited);
            check_value(name, expected, int'(sample_out));
        end
    endtask

    // Impulse at the first sample or random values
    function automatic int next_input(input int row, input int index);
        if (!row_random[row]) return (index == 0) ? row_amp[row] : 0;
        if (row_sat[row]) return int'(sample_t'($urandom));
        return int'($urandom % (2 * row_amp[row] + 1)) - row_amp[row];
    endfunction

    task automatic set_mode(input int row, input int amp, input bit rnd, input bit sat,
                            input int count, input int gap, input int sw, input int new_len);
        row_amp[row]     = amp;
        row_random[row]  = rnd;
        row_sat[row]     = sat;
        row_count[row]   = count;
        row_gap[row]     = gap;
        row_switch[row]  = sw;
        row_new_len[row] = new_len;
    endtask

    task automatic load_table();
        row_name[0]  = "zero_gain";
        row_delay[0] = '{64, 64, 64, 64};
        row_gain[0]  = '{0, 0, 0, 0};
        set_mode(0, 255, 1'b1, 1'b0, 24, 0, -1, 0);
        row_name[1]  = "impulse_echo";
        row_delay[1] = '{5, 7, 11, 13};
        row_gain[1]  = '{96, 80, -64, 112};
        set_mode(1, 1000, 1'b0, 1'b0, 60, 0, -1, 0);
        row_name[2]  = "saturation";
        row_delay[2] = '{3, 4, 5, 6};
        row_gain[2]  = '{127, -128, 127, -127};
        set_mode(2, 0, 1'b1, 1'b1, 50, 0, -1, 0);
        // Zero delay written right after the first echo becomes 1
        row_name[3]  = "rewrite_zero";
        row_delay[3] = '{8, 8, 8, 8};
        row_gain[3]  = '{100, 0, 0, 0};
        set_mode(3, 800, 1'b0, 1'b0, 30, 0, 9, 0);
        // Oversized delay becomes DELAY_MAX
        row_name[4]  = "rewrite_big";
        row_delay[4] = '{4, 9, 16, 20};
        row_gain[4]  = '{90, 90, 90, 90};
        set_mode(4, 600, 1'b0, 1'b0, 80, 0, 12, 200);
        row_name[5]  = "idle_gaps";
        row_delay[5] = '{6, 10, 3, 17};
        row_gain[5]  = '{70, -90, 50, -100};
        set_mode(5, 400, 1'b1, 1'b0, 40, 3, -1, 0);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        void'($urandom(32'h5b0271e6));
        rstn         = 1'b0;
        sample_valid = 1'b0;
        sample_in    = '0;
        cfg_write    = 1'b0;
        cfg_index    = '0;
        cfg_delay    = '0;
        cfg_gain     = '0;
        errors       = 0;
        checks       = 0;
        load_table();
        table_ready = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            reset_bank(row_name[r]);
            for (int k = 0; k < `NUM_COMBS; k++) begin
                write_config(k, row_delay[r][k], row_gain[r][k]);
            end
            clamp_hits = 0;
            for (int i = 0; i < row_count[r]; i++) begin
                if (i == row_switch[r]) write_config(0, row_new_len[r], row_gain[r][0]);
                apply_sample($sformatf("%s[%0d]", row_name[r], i), next_input(r, i));
                // No strobe while idle
                repeat (row_gap[r]) begin
                    @(negedge clk);
                    check_value({row_name[r], " idle out_valid"}, 0, int'(out_valid));
                end
            end
            if (row_sat[r] && clamp_hits == 0) begin
                errors++;
                $display("%s: input never drove a filter into saturation", row_name[r]);
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Limit from sample count and spacing plus reset and config time
    initial begin
        int limit;
        wait (table_ready);
        limit = 50;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit += row_count[r] * (row_gap[r] + 2) + 20;
        end
        #(limit * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d clock cycles", limit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: sources.f
+incdir+source
source/audio_sample_pkg.sv
source/comb_config_pkg.sv
source/sample_delay_line.sv
source/comb_filter.sv
source/comb_config_regs.sv
source/comb_mixer.sv
source/comb_bank_top.sv
tests/comb_bank_sva.sv
tests/comb_bank_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := comb_bank_tb
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_TEXT  := NO ERRORS
FLAGS      := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES) source/comb_settings.svh
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
